// ==== msu.f ====
hdl/msu_pkg.sv
hdl/msu_bus_sync.sv
hdl/msu_databuf.sv
hdl/msu_regs.sv
hdl/msu_data_port.sv
hdl/msu_top.sv
sim/msu_tb.sv

// ==== sim/msu_tb.sv ====
module msu_tb import msu_pkg::*; ();

  // Well above the length of all tests together
  localparam int MAX_CYCLES = 20000;
  localparam logic [MSU_PTR_W-1:0] STREAM_BASE = 14'h3FEC;

  logic clkin = 1'b0;
  logic rst, enable, pgm_we_n, status_reset_we, msu_address_ext_write, reg_oe, reg_we;
  logic [MSU_PTR_W-1:0]   pgm_address, msu_address_ext;
  logic [MSU_DATA_W-1:0]  pgm_data, reg_data_in, reg_data_out, volume_out;
  logic [MSU_SBITS_W-1:0] status_reset_bits, status_set_bits;
  logic [MSU_REG_W-1:0]   reg_addr;
  logic [MSU_STAT_W-1:0]  status_out;
  logic [MSU_SEEK_W-1:0]  addr_out;
  logic [MSU_TRACK_W-1:0] track_out;
  logic                   volume_latch_out;
  logic [31:0]            lcg_state = 32'hc4b6827b;
  logic [MSU_DATA_W-1:0]  stream_exp [44];
  int cycles = 0, vol_count = 0, errors = 0, checks = 0, tests = 0;

  msu_top dut_i (
    .clkin(clkin), .rst(rst), .enable(enable), .pgm_address(pgm_address),
    .pgm_data(pgm_data), .pgm_we_n(pgm_we_n), .status_reset_bits(status_reset_bits),
    .status_set_bits(status_set_bits), .status_reset_we(status_reset_we),
    .msu_address_ext(msu_address_ext), .msu_address_ext_write(msu_address_ext_write),
    .reg_addr(reg_addr), .reg_data_in(reg_data_in), .reg_data_out(reg_data_out),
    .reg_oe(reg_oe), .reg_we(reg_we), .status_out(status_out), .volume_out(volume_out),
    .volume_latch_out(volume_latch_out), .addr_out(addr_out), .track_out(track_out)
  );

  always #10 clkin = ~clkin;

  always @(negedge clkin) begin
    if (volume_latch_out) vol_count <= vol_count + 1;
  end

  always @(posedge clkin) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_byte(input logic [MSU_DATA_W-1:0] got, exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_addr(input logic [MSU_SEEK_W-1:0] got, exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_track(input logic [MSU_TRACK_W-1:0] got, exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_status(input logic [MSU_STAT_W-1:0] got, exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    $display("Test %-18s %s (%0d errors)", name, (errors == err0) ? "ok" : "failed",
             errors - err0);
  endtask

  ////////////////////////////////////////
  // Bus and MCU drivers
  ////////////////////////////////////////
  task automatic bus_write(input logic [MSU_REG_W-1:0] a, input logic [MSU_DATA_W-1:0] d);
    @(posedge clkin);
    reg_addr    <= a;
    reg_data_in <= d;
    @(posedge clkin);
    reg_we <= 1'b1;
    repeat (4) @(posedge clkin);
    reg_we <= 1'b0;
    repeat (4) @(posedge clkin);
  endtask

  // Data is sampled mid-cycle while reg_oe is low
  task automatic bus_read(input logic [MSU_REG_W-1:0] a, output logic [MSU_DATA_W-1:0] d);
    @(posedge clkin);
    reg_addr <= a;
    reg_oe   <= 1'b0;
    repeat (3) @(posedge clkin);
    @(negedge clkin);
    d = reg_data_out;
    @(posedge clkin);
    reg_oe <= 1'b1;
    repeat (4) @(posedge clkin);
  endtask

  task automatic mcu_status(input logic [MSU_SBITS_W-1:0] set_b, rst_b);
    @(posedge clkin);
    status_set_bits   <= set_b;
    status_reset_bits <= rst_b;
    @(posedge clkin);
    status_reset_we <= 1'b1;
    repeat (4) @(posedge clkin);
    status_reset_we <= 1'b0;
    repeat (4) @(posedge clkin);
  endtask

  task automatic mcu_seek(input logic [MSU_PTR_W-1:0] a);
    @(posedge clkin);
    msu_address_ext <= a;
    @(posedge clkin);
    msu_address_ext_write <= 1'b1;
    repeat (4) @(posedge clkin);
    msu_address_ext_write <= 1'b0;
    repeat (4) @(posedge clkin);
  endtask

  task automatic mcu_load(input logic [MSU_PTR_W-1:0] a, input logic [MSU_DATA_W-1:0] d);
    @(posedge clkin);
    pgm_address <= a;
    pgm_data    <= d;
    pgm_we_n    <= 1'b0;
    repeat (4) @(posedge clkin);
    pgm_we_n <= 1'b1;
    repeat (4) @(posedge clkin);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic test_reset_id();
    int err0;
    string id_str;
    logic [MSU_DATA_W-1:0] d;
    err0 = errors;
    id_str = "S-MSU1";
    bus_read(REG_STATUS, d);
    check_byte(d, 8'hC1, "status read after reset");
    check_status(status_out, 7'h00, "status_out after reset");
    check_bit(volume_latch_out, 1'b0, "volume latch after reset");
    for (int i = 0; i < 6; i++) begin
      bus_read(3'(i + 2), d);
      check_byte(d, id_str[i], "identifier byte");
    end
    end_test("reset and ID", err0);
  endtask

  task automatic test_seek_regs();
    int err0;
    logic [MSU_DATA_W-1:0] d;
    err0 = errors;
    // Drop data busy first so the seek write has to raise it again
    mcu_status(6'b000000, 6'b010000);
    bus_read(REG_STATUS, d);
    check_byte(d, 8'h41, "status read before seek writes");
    bus_write(REG_SEEK0, 8'h78);
    bus_write(REG_SEEK1, 8'h56);
    bus_write(REG_SEEK2, 8'h34);
    bus_write(REG_SEEK3, 8'h12);
    check_addr(addr_out, 32'h1234_5678, "seek address");
    check_bit(status_out[4], 1'b1, "data start after seek write");
    bus_read(REG_STATUS, d);
    check_byte(d, 8'hC1, "status read with data busy");
    mcu_status(6'b000000, 6'b010000);
    check_bit(status_out[4], 1'b0, "data start after MCU clear");
    bus_read(REG_STATUS, d);
    check_byte(d, 8'h41, "status read after data busy clear");
    mcu_status(6'b000110, 6'b000000);
    bus_read(REG_STATUS, d);
    check_byte(d, 8'h71, "status read with audio status set");
    mcu_status(6'b000000, 6'b000110);
    end_test("seek registers", err0);
  endtask

  task automatic test_track_volume();
    int err0, vol_mark;
    err0 = errors;
    bus_write(REG_TRACK0, 8'hBE);
    bus_write(REG_TRACK1, 8'hEF);
    check_track(track_out, 16'hEFBE, "track number");
    check_status(status_out, 7'h20, "audio start after track write");
    vol_mark = vol_count;
    bus_write(REG_VOLUME, 8'hA5);
    check_byte(volume_out, 8'hA5, "volume");
    check_addr(32'(vol_count - vol_mark), 32'd1, "volume latch cycles");
    end_test("track and volume", err0);
  endtask

  task automatic test_ctrl_gating();
    int err0;
    logic [MSU_DATA_W-1:0] d;
    err0 = errors;
    bus_write(REG_CTRL, 8'h03);
    check_status(status_out, 7'h20, "control write while audio busy");
    mcu_status(6'b000000, 6'b100000);
    check_status(status_out, 7'h00, "audio start after busy clear");
    bus_read(REG_STATUS, d);
    check_byte(d, 8'h01, "status read with both busy clear");
    bus_write(REG_CTRL, 8'h03);
    check_status(status_out, 7'h07, "control field and start");
    end_test("control gating", err0);
  endtask

  task automatic test_streaming();
    int err0;
    logic [MSU_PTR_W-1:0] next_ptr;
    logic [MSU_DATA_W-1:0] d;
    err0 = errors;
    for (int i = 0; i < 40; i++) begin
      lcg_state = lcg_next(lcg_state);
      stream_exp[i] = lcg_state[23:16];
      mcu_load(STREAM_BASE + 14'(i), stream_exp[i]);
    end
    mcu_seek(STREAM_BASE);
    check_bit(status_out[6], 1'b1, "pointer MSB after seek");
    for (int i = 0; i < 40; i++) begin
      bus_read(REG_DATA, d);
      check_byte(d, stream_exp[i], "streamed byte");
      next_ptr = STREAM_BASE + 14'(i + 1);
      check_bit(status_out[6], next_ptr[MSU_PTR_W-1], "pointer MSB while streaming");
    end
    end_test("streaming", err0);
  endtask

  task automatic test_enable_low();
    int err0, vol_mark;
    logic [MSU_DATA_W-1:0] d;
    err0 = errors;
    for (int i = 40; i < 44; i++) begin
      lcg_state = lcg_next(lcg_state);
      stream_exp[i] = lcg_state[23:16];
      mcu_load(STREAM_BASE + 14'(i), stream_exp[i]);
    end
    mcu_seek(STREAM_BASE + 14'd40);
    bus_read(REG_DATA, d);
    check_byte(d, stream_exp[40], "byte after seek");
    @(posedge clkin);
    enable <= 1'b0;
    vol_mark = vol_count;
    bus_write(REG_SEEK0, 8'hFF);
    bus_write(REG_TRACK1, 8'h00);
    bus_write(REG_VOLUME, 8'h11);
    bus_write(REG_CTRL, 8'h00);
    check_addr(addr_out, 32'h1234_5678, "seek address while disabled");
    check_track(track_out, 16'hEFBE, "track while disabled");
    check_byte(volume_out, 8'hA5, "volume while disabled");
    check_status(status_out, 7'h07, "status_out while disabled");
    check_addr(32'(vol_count - vol_mark), 32'd0, "volume latch while disabled");
    bus_read(REG_DATA, d);
    bus_read(REG_DATA, d);
    @(posedge clkin);
    enable <= 1'b1;
    bus_read(REG_DATA, d);
    check_byte(d, stream_exp[41], "first byte after enable");
    bus_read(REG_DATA, d);
    check_byte(d, stream_exp[42], "second byte after enable");
    end_test("enable low", err0);
  endtask

  initial begin
    rst                   <= 1'b1;
    enable                <= 1'b1;
    pgm_address           <= '0;
    pgm_data              <= '0;
    pgm_we_n              <= 1'b1;
    status_reset_bits     <= '0;
    status_set_bits       <= '0;
    status_reset_we       <= 1'b0;
    msu_address_ext       <= '0;
    msu_address_ext_write <= 1'b0;
    reg_addr              <= '0;
    reg_data_in           <= '0;
    reg_oe                <= 1'b1;
    reg_we                <= 1'b0;
    repeat (3) @(posedge clkin);
    rst <= 1'b0;
    test_reset_id();
    test_seek_regs();
    test_track_volume();
    test_ctrl_gating();
    test_streaming();
    test_enable_low();
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/msu_top.sv ====
module msu_top import msu_pkg::*; (
  input  logic                   clkin,
  input  logic                   rst,
  input  logic                   enable,
  // MCU side
  input  logic [MSU_PTR_W-1:0]   pgm_address,
  input  logic [MSU_DATA_W-1:0]  pgm_data,
  input  logic                   pgm_we_n,
  input  logic [MSU_SBITS_W-1:0] status_reset_bits,
  input  logic [MSU_SBITS_W-1:0] status_set_bits,
  input  logic                   status_reset_we,
  input  logic [MSU_PTR_W-1:0]   msu_address_ext,
  input  logic                   msu_address_ext_write,
  // Console side
  input  logic [MSU_REG_W-1:0]   reg_addr,
  input  logic [MSU_DATA_W-1:0]  reg_data_in,
  output logic [MSU_DATA_W-1:0]  reg_data_out,
  input  logic                   reg_oe,
  input  logic                   reg_we,
  // Audio and status outputs
  output logic [MSU_STAT_W-1:0]  status_out,
  output logic [MSU_DATA_W-1:0]  volume_out,
  output logic                   volume_latch_out,
  output logic [MSU_SEEK_W-1:0]  addr_out,
  output logic [MSU_TRACK_W-1:0] track_out
);

  logic                  we_pulse;
  logic                  rd_done_pulse;
  logic                  status_pulse;
  logic                  seek_pulse;
  logic [MSU_PTR_W-1:0]  buf_addr;
  logic [MSU_DATA_W-1:0] buf_dout;
  logic [MSU_DATA_W-1:0] stream_byte;
  logic                  ptr_msb;
  logic [5:0]            flag_bits;

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////
  msu_bus_sync sync_i (
    .clkin(clkin), .rst(rst), .enable(enable),
    .reg_we(reg_we), .reg_oe(reg_oe),
    .status_reset_we(status_reset_we), .msu_address_ext_write(msu_address_ext_write),
    .we_pulse(we_pulse), .rd_done_pulse(rd_done_pulse),
    .status_pulse(status_pulse), .seek_pulse(seek_pulse)
  );

  ////////////////////////////////////////
  // Buffer, registers and stream port
  ////////////////////////////////////////
  msu_databuf buf_i (
    .clkin(clkin), .pgm_we_n(pgm_we_n), .pgm_address(pgm_address),
    .pgm_data(pgm_data), .buf_addr(buf_addr), .buf_dout(buf_dout)
  );

  msu_regs regs_i (
    .clkin(clkin), .rst(rst), .we_pulse(we_pulse), .status_pulse(status_pulse),
    .reg_addr(reg_addr), .reg_data_in(reg_data_in),
    .status_set_bits(status_set_bits), .status_reset_bits(status_reset_bits),
    .stream_byte(stream_byte), .reg_data_out(reg_data_out),
    .addr_out(addr_out), .track_out(track_out), .volume_out(volume_out),
    .volume_latch_out(volume_latch_out), .flag_bits(flag_bits)
  );

  msu_data_port port_i (
    .clkin(clkin), .rst(rst), .rd_done_pulse(rd_done_pulse), .seek_pulse(seek_pulse),
    .reg_addr(reg_addr), .msu_address_ext(msu_address_ext), .buf_dout(buf_dout),
    .buf_addr(buf_addr), .stream_byte(stream_byte), .ptr_msb(ptr_msb)
  );

  // Pointer MSB on top of the start flags and control field
  assign status_out = {ptr_msb, flag_bits};

endmodule

// ==== hdl/msu_data_port.sv ====
module msu_data_port import msu_pkg::*; (
  input  logic                  clkin,
  input  logic                  rst,
  input  logic                  rd_done_pulse,
  input  logic                  seek_pulse,
  input  logic [MSU_REG_W-1:0]  reg_addr,
  input  logic [MSU_PTR_W-1:0]  msu_address_ext,
  input  logic [MSU_DATA_W-1:0] buf_dout,
  output logic [MSU_PTR_W-1:0]  buf_addr,
  output logic [MSU_DATA_W-1:0] stream_byte,
  output logic                  ptr_msb
);

  logic [MSU_PTR_W-1:0] ptr;
  logic [1:0]           pend;
  logic                 rd_step;

  // Only completed reads of the data register advance the stream
  assign rd_step = rd_done_pulse && (reg_addr == REG_DATA);

  ////////////////////////////////////////
  // Pointer
  ////////////////////////////////////////
  always_ff @(posedge clkin) begin
    if (rst) begin
      ptr <= '0;
    end else if (seek_pulse) begin
      ptr <= msu_address_ext;
    end else if (rd_step) begin
      // Wraps at the end of the buffer
      ptr <= ptr + 1'b1;
    end
  end

  assign buf_addr = ptr;
  assign ptr_msb  = ptr[MSU_PTR_W-1];

  ////////////////////////////////////////
  // Prefetch into the data latch
  ////////////////////////////////////////
  // One stage per cycle of RAM read latency, overlapping changes stay in flight
  always_ff @(posedge clkin) begin
    if (rst) begin
      pend <= '0;
    end else begin
      pend <= {pend[0], seek_pulse | rd_step};
    end
  end

  always_ff @(posedge clkin) begin
    if (pend[1]) begin
      stream_byte <= buf_dout;
    end
  end

  a_ptr_stable: assert property (
    @(posedge clkin) disable iff (rst) !(seek_pulse || rd_step) |=> $stable(ptr)
  );

endmodule

// ==== hdl/msu_regs.sv ====
module msu_regs import msu_pkg::*; (
  input  logic                   clkin,
  input  logic                   rst,
  input  logic                   we_pulse,
  input  logic                   status_pulse,
  input  logic [MSU_REG_W-1:0]   reg_addr,
  input  logic [MSU_DATA_W-1:0]  reg_data_in,
  input  logic [MSU_SBITS_W-1:0] status_set_bits,
  input  logic [MSU_SBITS_W-1:0] status_reset_bits,
  input  logic [MSU_DATA_W-1:0]  stream_byte,
  output logic [MSU_DATA_W-1:0]  reg_data_out,
  output logic [MSU_SEEK_W-1:0]  addr_out,
  output logic [MSU_TRACK_W-1:0] track_out,
  output logic [MSU_DATA_W-1:0]  volume_out,
  output logic                   volume_latch_out,
  output logic [5:0]             flag_bits
);

  logic       audio_start;
  logic       audio_busy;
  logic       data_start;
  logic       data_busy;
  logic       ctrl_start;
  logic [1:0] audio_ctrl;
  logic [1:0] audio_status;

  ////////////////////////////////////////
  // Console writes and MCU status
  ////////////////////////////////////////
  always_ff @(posedge clkin) begin
    if (rst) begin
      addr_out     <= '0;
      track_out    <= '0;
      volume_out   <= '0;
      audio_start  <= 1'b0;
      audio_busy   <= 1'b1;
      data_start   <= 1'b0;
      data_busy    <= 1'b1;
      ctrl_start   <= 1'b0;
      audio_ctrl   <= '0;
      audio_status <= '0;
    end else if (we_pulse) begin
      case (reg_addr)
        REG_SEEK0: addr_out[7:0]   <= reg_data_in;
        REG_SEEK1: addr_out[15:8]  <= reg_data_in;
        REG_SEEK2: addr_out[23:16] <= reg_data_in;
        REG_SEEK3: begin
          addr_out[31:24] <= reg_data_in;
          data_start      <= 1'b1;
          data_busy       <= 1'b1;
        end
        REG_TRACK0: track_out[7:0] <= reg_data_in;
        REG_TRACK1: begin
          track_out[15:8] <= reg_data_in;
          audio_start     <= 1'b1;
          audio_busy      <= 1'b1;
        end
        REG_VOLUME: volume_out <= reg_data_in;
        REG_CTRL: begin
          // Ignored while a track is still being prepared
          if (!audio_busy) begin
            audio_ctrl <= reg_data_in[1:0];
            ctrl_start <= 1'b1;
          end
        end
        default: ;
      endcase
    end else if (status_pulse) begin
      audio_busy <= (audio_busy | status_set_bits[SB_AUDIO_BUSY])
                    & ~status_reset_bits[SB_AUDIO_BUSY];
      if (status_reset_bits[SB_AUDIO_BUSY]) begin
        audio_start <= 1'b0;
      end
      data_busy <= (data_busy | status_set_bits[SB_DATA_BUSY])
                   & ~status_reset_bits[SB_DATA_BUSY];
      if (status_reset_bits[SB_DATA_BUSY]) begin
        data_start <= 1'b0;
      end
      audio_status <= (audio_status | status_set_bits[SB_AUDIO_ST_HI:SB_AUDIO_ST_LO])
                      & ~status_reset_bits[SB_AUDIO_ST_HI:SB_AUDIO_ST_LO];
      ctrl_start <= (ctrl_start | status_set_bits[SB_CTRL_START])
                    & ~status_reset_bits[SB_CTRL_START];
    end
  end

  // Volume strobe for the audio side
  always_ff @(posedge clkin) begin
    if (rst) begin
      volume_latch_out <= 1'b0;
    end else begin
      volume_latch_out <= we_pulse && (reg_addr == REG_VOLUME);
    end
  end

  assign flag_bits = {audio_start, data_start, volume_latch_out, audio_ctrl, ctrl_start};

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////
  always_ff @(posedge clkin) begin
    if (rst) begin
      reg_data_out <= '0;
    end else begin
      case (reg_addr)
        REG_STATUS: reg_data_out <= {data_busy, audio_busy, audio_status, STATUS_LOW_NIBBLE};
        REG_DATA:   reg_data_out <= stream_byte;
        3'd2:       reg_data_out <= MSU_ID0;
        3'd3:       reg_data_out <= MSU_ID1;
        3'd4:       reg_data_out <= MSU_ID2;
        3'd5:       reg_data_out <= MSU_ID3;
        3'd6:       reg_data_out <= MSU_ID4;
        default:    reg_data_out <= MSU_ID5;
      endcase
    end
  end

  a_vol_single: assert property (
    @(posedge clkin) disable iff (rst) volume_latch_out |=> !volume_latch_out
  );

endmodule

// ==== hdl/msu_databuf.sv ====
module msu_databuf import msu_pkg::*; (
  input  logic                  clkin,
  input  logic                  pgm_we_n,
  input  logic [MSU_PTR_W-1:0]  pgm_address,
  input  logic [MSU_DATA_W-1:0] pgm_data,
  input  logic [MSU_PTR_W-1:0]  buf_addr,
  output logic [MSU_DATA_W-1:0] buf_dout
);

  localparam int DEPTH = 2 ** MSU_PTR_W;

  logic [MSU_DATA_W-1:0] mem [DEPTH];

  ////////////////////////////////////////
  // MCU write port
  ////////////////////////////////////////
  always_ff @(posedge clkin) begin
    if (!pgm_we_n) begin
      mem[pgm_address] <= pgm_data;
    end
  end

  ////////////////////////////////////////
  // Stream read port
  ////////////////////////////////////////
  // Registered output, one cycle behind buf_addr
  always_ff @(posedge clkin) begin
    buf_dout <= mem[buf_addr];
  end

endmodule

// ==== hdl/msu_bus_sync.sv ====
module msu_bus_sync import msu_pkg::*; (
  input  logic clkin,
  input  logic rst,
  input  logic enable,
  input  logic reg_we,
  input  logic reg_oe,
  input  logic status_reset_we,
  input  logic msu_address_ext_write,
  output logic we_pulse,
  output logic rd_done_pulse,
  output logic status_pulse,
  output logic seek_pulse
);

  // High once, then three lows in a row (oldest sample in bit 3)
  localparam logic [3:0] OE_FILTER = 4'b1000;

  logic [2:0] stb_d1;
  logic [2:0] stb_d2;
  logic [2:0] stb_rise;
  logic [3:0] oe_hist;

  ////////////////////////////////////////
  // Strobe histories
  ////////////////////////////////////////
  // Bit 0 write, bit 1 status, bit 2 seek
  always_ff @(posedge clkin) begin
    if (rst) begin
      stb_d1  <= '1;
      stb_d2  <= '1;
      oe_hist <= '1;
    end else begin
      stb_d1  <= {msu_address_ext_write, status_reset_we, reg_we};
      stb_d2  <= stb_d1;
      oe_hist <= {oe_hist[2:0], reg_oe};
    end
  end

  assign stb_rise = stb_d1 & ~stb_d2;

  ////////////////////////////////////////
  // Event pulses
  ////////////////////////////////////////
  always_ff @(posedge clkin) begin
    if (rst) begin
      we_pulse      <= 1'b0;
      rd_done_pulse <= 1'b0;
      status_pulse  <= 1'b0;
      seek_pulse    <= 1'b0;
    end else begin
      // Console side only acts while enabled
      we_pulse      <= stb_rise[0] & enable;
      rd_done_pulse <= (oe_hist == OE_FILTER) & enable;
      status_pulse  <= stb_rise[1];
      seek_pulse    <= stb_rise[2];
    end
  end

  property one_cycle(sig);
    @(posedge clkin) disable iff (rst) sig |=> !sig;
  endproperty

  a_we_one:     assert property (one_cycle(we_pulse));
  a_rd_one:     assert property (one_cycle(rd_done_pulse));
  a_status_one: assert property (one_cycle(status_pulse));
  a_seek_one:   assert property (one_cycle(seek_pulse));

endmodule

// ==== hdl/msu_pkg.sv ====
package msu_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////
  localparam int MSU_PTR_W   = 14;
  localparam int MSU_DATA_W  = 8;
  localparam int MSU_REG_W   = 3;
  localparam int MSU_SEEK_W  = 32;
  localparam int MSU_TRACK_W = 16;
  localparam int MSU_STAT_W  = 7;
  localparam int MSU_SBITS_W = 6;

  ////////////////////////////////////////
  // Register window indices
  ////////////////////////////////////////
  // Write side
  localparam logic [MSU_REG_W-1:0] REG_SEEK0  = 3'd0;
  localparam logic [MSU_REG_W-1:0] REG_SEEK1  = 3'd1;
  localparam logic [MSU_REG_W-1:0] REG_SEEK2  = 3'd2;
  localparam logic [MSU_REG_W-1:0] REG_SEEK3  = 3'd3;
  localparam logic [MSU_REG_W-1:0] REG_TRACK0 = 3'd4;
  localparam logic [MSU_REG_W-1:0] REG_TRACK1 = 3'd5;
  localparam logic [MSU_REG_W-1:0] REG_VOLUME = 3'd6;
  localparam logic [MSU_REG_W-1:0] REG_CTRL   = 3'd7;
  // Read side
  localparam logic [MSU_REG_W-1:0] REG_STATUS = 3'd0;
  localparam logic [MSU_REG_W-1:0] REG_DATA   = 3'd1;

  // Bit positions in the MCU set and reset fields
  localparam int SB_AUDIO_BUSY  = 5;
  localparam int SB_DATA_BUSY   = 4;
  localparam int SB_AUDIO_ST_HI = 2;
  localparam int SB_AUDIO_ST_LO = 1;
  localparam int SB_CTRL_START  = 0;

  // Identifier "S-MSU1"
  localparam logic [MSU_DATA_W-1:0] MSU_ID0 = 8'h53;
  localparam logic [MSU_DATA_W-1:0] MSU_ID1 = 8'h2D;
  localparam logic [MSU_DATA_W-1:0] MSU_ID2 = 8'h4D;
  localparam logic [MSU_DATA_W-1:0] MSU_ID3 = 8'h53;
  localparam logic [MSU_DATA_W-1:0] MSU_ID4 = 8'h55;
  localparam logic [MSU_DATA_W-1:0] MSU_ID5 = 8'h31;

  localparam logic [3:0] STATUS_LOW_NIBBLE = 4'h1;

endpackage
